// ==== project.f ====
+incdir+.
mouse_pkg.sv
ps2_rx.sv
ps2_tx.sv
mouse_link.sv
cursor_tracker.sv
mouse_top.sv
tb_ps2_mouse.sv
tb_mouse_top.sv

// ==== Makefile ====
# Verilator build and run of the PS/2 mouse testbench

VERILATOR ?= verilator
TOP       ?= tb_mouse_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# fails unless the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_mouse_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mouse_config.svh"

module tb_mouse_top;

   import mouse_pkg::*;

   // rough count of frames over the whole run
   localparam int FRAMES      = 70;
   // twice 11 bits of 10 us per frame plus the inhibit
   localparam int WATCHDOG_NS = 2 * (FRAMES * 11 * 10_000 + `MOUSE_INHIBIT_CYCLES * 20);
   // last frame to new position
   localparam int SETTLE      = `MOUSE_FILTER_LEN + 3;

   logic        CLK50MHZ;
   logic        RST;
   wire         ps2_clk;
   wire         ps2_data;
   wire  [7:0]  led;
   cursor_pos_t position;
   wire         debug_a;
   wire         debug_b;

   int          checks  = 0;
   int          errors  = 0;
   int          seed    = 32'h15ac;
   int          exp_pos = 0;

   mouse_top dut (
      .CLK50MHZ(CLK50MHZ), .RST(RST),
      .ps2_clk(ps2_clk), .ps2_data(ps2_data),
      .led(led), .position(position),
      .debug_a(debug_a), .debug_b(debug_b)
   );

   // device side of both lines with the pull-ups
   tb_ps2_mouse mouse (.clk(CLK50MHZ), .ps2_clk(ps2_clk), .ps2_data(ps2_data));

   initial begin
      CLK50MHZ = 1'b0;
      forever #10 CLK50MHZ = ~CLK50MHZ;
   end

   // left clears and right sets all ones, otherwise the signed step is added
   function automatic int next_pos(input int pos, input logic left, input logic right,
                                   input logic [8:0] step);
      int delta;
      delta = step[8] ? int'(step) - 512 : int'(step);
      if (left)
         return 0;
      if (right)
         return 1023;
      return (pos + delta + 1024) % 1024;
   endfunction

   // position, led value and one-hot led
   task automatic check_state(input int pos);
      logic [7:0] exp_led;
      // eighth 0 lights led 7
      exp_led = 8'h01 << (7 - pos / 128);
      checks++;
      assert (position === cursor_pos_t'(pos)) else begin
         errors++;
         $display("FAILED position got %h expected %h", position, pos[9:0]);
      end
      assert (led === exp_led) else begin
         errors++;
         $display("FAILED led got %h expected %h", led, exp_led);
      end
      assert ($onehot(led)) else begin
         errors++;
         $display("led does not have exactly one bit lit");
      end
   endtask

   // until the position moves or the latency bound runs out
   task automatic wait_settle(input cursor_pos_t old);
      int n;
      n = 0;
      // step off the device edge first
      @(posedge CLK50MHZ);
      @(negedge CLK50MHZ);
      while (position === old && n < SETTLE) begin
         @(negedge CLK50MHZ);
         n++;
      end
   endtask

   // byte 2 goes out while its last clock edge starts the latency bound
   task automatic send_packet(input logic left, input logic right, input logic [8:0] step,
                              input logic bad_dx, input int expected);
      mouse_packet_t pkt;
      cursor_pos_t   old;
      pkt            = '0;
      pkt.sync       = 1'b1;
      pkt.btn_left   = left;
      pkt.btn_right  = right;
      pkt.btn_middle = 1'($random(seed));
      pkt.x_sign     = step[8];
      pkt.dx         = step[7:0];
      // zero dy on a damaged packet so byte 2 cannot pass as a header
      pkt.dy         = bad_dx ? 8'h00 : 8'($random(seed));
      old            = position;
      mouse.send_byte(pkt[23:16], 1'b0);
      mouse.send_byte(pkt[15:8], bad_dx);
      fork
         mouse.send_byte(pkt[7:0], 1'b0);
         begin
            // eleventh falling edge ends the frame
            repeat (11) @(negedge ps2_clk);
            wait_settle(old);
            check_state(expected);
         end
      join
   endtask

   task automatic run_packet(input logic left, input logic right, input logic [8:0] step);
      exp_pos = next_pos(exp_pos, left, right, step);
      send_packet(left, right, step, 1'b0, exp_pos);
   endtask

   // debug pins must mirror the raw lines at every sample
   always @(negedge CLK50MHZ) begin
      #5;
      assert (debug_a === ps2_clk) else begin
         errors++;
         $display("FAILED debug_a got %h expected %h", debug_a, ps2_clk);
      end
      assert (debug_b === ps2_data) else begin
         errors++;
         $display("FAILED debug_b got %h expected %h", debug_b, ps2_data);
      end
   end

   initial begin
      logic [7:0] cmd;
      logic       parity;
      logic       stop;
      logic [8:0] step;
      int         i;
      RST = 1'b1;
      repeat (2) @(negedge CLK50MHZ);
      RST = 1'b0;
      @(negedge CLK50MHZ);
      check_state(0);

      // start-up command and the device answer
      mouse.take_command(cmd, parity, stop);
      checks++;
      assert (cmd === `MOUSE_CMD_STREAM) else begin
         errors++;
         $display("FAILED cmd got %h expected %h", cmd, `MOUSE_CMD_STREAM);
      end
      assert (^{cmd, parity} === 1'b1) else begin
         errors++;
         $display("command parity bit does not give odd parity");
      end
      assert (stop === 1'b1) else begin
         errors++;
         $display("command stop bit was low");
      end
      mouse.send_byte(`MOUSE_ACK, 1'b0);

      // random motion without buttons
      for (i = 0; i < 16; i++) begin
         step = 9'($random(seed));
         // first step negative so the sum wraps below zero
         if (i == 0)
            step[8] = 1'b1;
         run_packet(1'b0, 1'b0, step);
      end

      // left button beats right
      run_packet(1'b1, 1'b0, 9'h023);
      run_packet(1'b0, 1'b1, 9'h1f0);
      run_packet(1'b1, 1'b1, 9'h07e);

      // bad parity in byte 1 must not move the cursor
      send_packet(1'b0, 1'b0, 9'h040, 1'b1, exp_pos);
      run_packet(1'b0, 1'b0, 9'h011);
      // header byte with sync clear is dropped
      mouse.send_byte(8'h00, 1'b0);
      run_packet(1'b0, 1'b0, 9'h1c5);

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests finished");
      $display("checks: %0d  errors: %0d", checks, errors);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_ps2_mouse.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_mouse (
   input wire clk,
   inout wire ps2_clk,
   inout wire ps2_data
);

   // device clock, 5 us low and 5 us high
   localparam int HALF_NS    = 5000;
   localparam int QUARTER_NS = 2500;
   // line ack clock, a brief pulse
   localparam int ACK_LOW_NS = 100;
   // idle time after each frame
   localparam int GAP_NS     = 20000;

   logic clk_low  = 1'b0;
   logic data_low = 1'b0;

   // open drain, pulled up when nobody drives
   assign ps2_clk  = clk_low ? 1'b0 : 1'bz;
   assign ps2_data = data_low ? 1'b0 : 1'bz;
   pullup (ps2_clk);
   pullup (ps2_data);

   // device-to-host frame: start, data lsb first, odd parity, stop
   task automatic send_byte(input logic [7:0] value, input logic bad_parity);
      logic [10:0] frame;
      int          i;
      frame = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
      @(negedge clk);
      for (i = 0; i < 11; i++) begin
         // data moves while the clock is high
         data_low = ~frame[i];
         #(QUARTER_NS);
         clk_low = 1'b1;
         #(HALF_NS);
         clk_low = 1'b0;
         #(QUARTER_NS);
      end
      data_low = 1'b0;
      #(GAP_NS);
   endtask

   // host request to send, 10 bits clocked in, then the line ack
   task automatic take_command(output logic [7:0] value, output logic parity,
                               output logic stop);
      logic [9:0] bits;
      int         i;
      // inhibit first, then clock let go with data held low
      wait (ps2_clk === 1'b0);
      wait (ps2_clk === 1'b1 && ps2_data === 1'b0);
      @(negedge clk);
      #(HALF_NS);
      for (i = 0; i < 10; i++) begin
         clk_low = 1'b1;
         #(HALF_NS);
         // sampled just before the rising edge
         bits[i] = ps2_data;
         clk_low = 1'b0;
         #(HALF_NS);
      end
      value  = bits[7:0];
      parity = bits[8];
      stop   = bits[9];
      // ack: data low across one more clock
      data_low = 1'b1;
      #(QUARTER_NS);
      clk_low = 1'b1;
      #(ACK_LOW_NS);
      clk_low = 1'b0;
      #(HALF_NS);
      data_low = 1'b0;
      #(GAP_NS);
   endtask

endmodule

`default_nettype wire

// ==== mouse_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mouse_top (
   input  wire                         CLK50MHZ,
   input  wire                         RST,
   inout  wire                         ps2_clk,
   inout  wire                         ps2_data,
   output wire [7:0]                   led,
   output wire mouse_pkg::cursor_pos_t position,
   output wire                         debug_a,
   output wire                         debug_b
);

   import mouse_pkg::*;

   // receive side
   ps2_byte_t     rx_byte;
   logic          rx_done;
   logic          rx_err;
   logic          rx_enable;
   // transmit side
   ps2_byte_t     tx_byte;
   logic          tx_start;
   logic          tx_busy;
   logic          tx_done;
   logic          tx_err;
   logic          clk_drive_low;
   logic          data_drive_low;
   // packets to the tracker
   mouse_packet_t packet;
   logic          packet_valid;

   // open drain, pull-ups are off chip
   assign ps2_clk  = clk_drive_low ? 1'b0 : 1'bz;
   assign ps2_data = data_drive_low ? 1'b0 : 1'bz;

   // raw line levels for the scope
   assign debug_a = ps2_clk;
   assign debug_b = ps2_data;

   ps2_rx u_rx (
      .CLK50MHZ(CLK50MHZ), .RST(RST),
      .ps2_clk(ps2_clk), .ps2_data(ps2_data), .enable(rx_enable),
      .rx_byte(rx_byte), .rx_done(rx_done), .rx_err(rx_err)
   );

   ps2_tx u_tx (
      .CLK50MHZ(CLK50MHZ), .RST(RST),
      .ps2_clk(ps2_clk), .ps2_data(ps2_data),
      .tx_byte(tx_byte), .tx_start(tx_start),
      .clk_drive_low(clk_drive_low), .data_drive_low(data_drive_low),
      .tx_busy(tx_busy), .tx_done(tx_done), .tx_err(tx_err)
   );

   mouse_link u_link (
      .CLK50MHZ(CLK50MHZ), .RST(RST),
      .rx_byte(rx_byte), .rx_done(rx_done), .rx_err(rx_err),
      .tx_busy(tx_busy), .tx_done(tx_done), .tx_err(tx_err),
      .tx_byte(tx_byte), .tx_start(tx_start), .rx_enable(rx_enable),
      .packet(packet), .packet_valid(packet_valid)
   );

   cursor_tracker u_tracker (
      .CLK50MHZ(CLK50MHZ), .RST(RST),
      .packet(packet), .packet_valid(packet_valid),
      .position(position), .led(led)
   );

endmodule

`default_nettype wire

// ==== cursor_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cursor_tracker (
   input  wire                      CLK50MHZ,
   input  wire                      RST,
   input  mouse_pkg::mouse_packet_t packet,
   input  wire                      packet_valid,
   output mouse_pkg::cursor_pos_t   position,
   output logic [7:0]               led
);

   import mouse_pkg::*;

   cursor_pos_t step;
   cursor_pos_t pos_next;

   // 9-bit signed x movement, sign-extended to 10 bits
   assign step = {packet.x_sign, packet.x_sign, packet.dx};

   // buttons win over motion, left over right
   always_comb begin
      if (packet.btn_left)
         pos_next = '0;
      else if (packet.btn_right)
         pos_next = '1;
      else
         pos_next = position + step;
   end

   always_ff @(posedge CLK50MHZ or posedge RST) begin
      if (RST)
         position <= '0;
      else if (packet_valid)
         position <= pos_next;
   end

   // top eighth picks the led, 0 lights led 7
   assign led = 8'h80 >> position[9:7];

endmodule

`default_nettype wire

// ==== mouse_link.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mouse_config.svh"

module mouse_link (
   input  wire                      CLK50MHZ,
   input  wire                      RST,
   input  mouse_pkg::ps2_byte_t     rx_byte,
   input  wire                      rx_done,
   input  wire                      rx_err,
   input  wire                      tx_busy,
   input  wire                      tx_done,
   input  wire                      tx_err,
   output mouse_pkg::ps2_byte_t     tx_byte,
   output logic                     tx_start,
   output logic                     rx_enable,
   output mouse_pkg::mouse_packet_t packet,
   output logic                     packet_valid
);

   import mouse_pkg::*;

   localparam logic [1:0] LK_START  = 2'd0;
   localparam logic [1:0] LK_CMD    = 2'd1;
   localparam logic [1:0] LK_ACK    = 2'd2;
   localparam logic [1:0] LK_STREAM = 2'd3;
   // sync flag position in byte 0
   localparam int         SYNC_BIT  = 3;

   logic [1:0] state;
   logic [1:0] byte_cnt;
   ps2_byte_t  hdr_q;
   ps2_byte_t  dx_q;
   logic       rx_ok;
   logic       rx_bad;

   // only command ever sent
   assign tx_byte   = `MOUSE_CMD_STREAM;
   // receiver is off while we own the bus
   assign rx_enable = ~tx_busy;
   assign rx_ok     = rx_done & ~tx_busy;
   assign rx_bad    = rx_err & ~tx_busy;

   always_ff @(posedge CLK50MHZ or posedge RST) begin
      if (RST) begin
         state        <= LK_START;
         byte_cnt     <= '0;
         tx_start     <= 1'b0;
         packet_valid <= 1'b0;
      end else begin
         tx_start     <= 1'b0;
         packet_valid <= 1'b0;
         case (state)
            LK_START: begin
               tx_start <= 1'b1;
               state    <= LK_CMD;
            end
            LK_CMD: begin
               // no retry; a failed command just falls through to listening
               if (tx_done)
                  state <= LK_ACK;
               else if (tx_err)
                  state <= LK_STREAM;
            end
            LK_ACK: begin
               // anything but FA is ignored here
               if (rx_ok && rx_byte == `MOUSE_ACK) begin
                  byte_cnt <= '0;
                  state    <= LK_STREAM;
               end
            end
            default: begin
               if (rx_bad) begin
                  // resync on a bad frame
                  byte_cnt <= '0;
               end else if (rx_ok) begin
                  case (byte_cnt)
                     2'd0: begin
                        if (rx_byte[SYNC_BIT])
                           byte_cnt <= 2'd1;
                     end
                     2'd1: byte_cnt <= 2'd2;
                     default: begin
                        byte_cnt     <= '0;
                        packet_valid <= 1'b1;
                     end
                  endcase
               end
            end
         endcase
      end
   end

   // packet bytes
   always_ff @(posedge CLK50MHZ) begin
      if (state == LK_STREAM && rx_ok) begin
         case (byte_cnt)
            2'd0: hdr_q <= rx_byte;
            2'd1: dx_q <= rx_byte;
            default: packet <= {hdr_q, dx_q, rx_byte};
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== ps2_tx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mouse_config.svh"

module ps2_tx (
   input  wire                  CLK50MHZ,
   input  wire                  RST,
   input  wire                  ps2_clk,
   input  wire                  ps2_data,
   input  mouse_pkg::ps2_byte_t tx_byte,
   input  wire                  tx_start,
   output logic                 clk_drive_low,
   output logic                 data_drive_low,
   output logic                 tx_busy,
   output logic                 tx_done,
   output logic                 tx_err
);

   localparam logic [1:0] ST_IDLE    = 2'd0;
   localparam logic [1:0] ST_INHIBIT = 2'd1;
   localparam logic [1:0] ST_BITS    = 2'd2;
   localparam logic [1:0] ST_ACK     = 2'd3;
   localparam int         CNT_W      = $clog2(`MOUSE_TX_TIMEOUT + 1);

   logic [1:0]       state;
   logic [CNT_W-1:0] timer;
   logic [3:0]       bit_cnt;
   // stop, parity, then data lsb first
   logic [9:0]       shift_q;
   logic [1:0]       data_sync;
   // bit 0 is the synchronizer stage
   logic [4:0]       clk_hist;
   logic             dev_fall;
   logic             timed_out;

   always_ff @(posedge CLK50MHZ or posedge RST) begin
      if (RST) begin
         clk_hist  <= '1;
         data_sync <= 2'b11;
      end else begin
         clk_hist  <= {clk_hist[3:0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
      end
   end

   // two highs then two lows, rejects single-cycle glitches
   assign dev_fall  = (clk_hist[4:1] == 4'b1100);
   assign timed_out = (timer == CNT_W'(`MOUSE_TX_TIMEOUT - 1));

   // hold clock low only while inhibiting
   assign clk_drive_low = (state == ST_INHIBIT);
   assign tx_busy       = (state != ST_IDLE);

   always_ff @(posedge CLK50MHZ or posedge RST) begin
      if (RST) begin
         state          <= ST_IDLE;
         timer          <= '0;
         bit_cnt        <= '0;
         data_drive_low <= 1'b0;
         tx_done        <= 1'b0;
         tx_err         <= 1'b0;
      end else begin
         tx_done <= 1'b0;
         tx_err  <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (tx_start) begin
                  timer <= '0;
                  state <= ST_INHIBIT;
               end
            end
            ST_INHIBIT: begin
               if (timer == CNT_W'(`MOUSE_INHIBIT_CYCLES - 1)) begin
                  // start bit goes low as the clock is let go
                  data_drive_low <= 1'b1;
                  timer          <= '0;
                  bit_cnt        <= '0;
                  state          <= ST_BITS;
               end else begin
                  timer <= timer + 1'b1;
               end
            end
            ST_BITS: begin
               if (timed_out) begin
                  data_drive_low <= 1'b0;
                  tx_err         <= 1'b1;
                  state          <= ST_IDLE;
               end else begin
                  timer <= timer + 1'b1;
                  // device samples on rising edge, we change on falling
                  if (dev_fall) begin
                     data_drive_low <= ~shift_q[0];
                     bit_cnt        <= bit_cnt + 4'd1;
                     if (bit_cnt == 4'd9)
                        state <= ST_ACK;
                  end
               end
            end
            default: begin
               if (timed_out) begin
                  tx_err <= 1'b1;
                  state  <= ST_IDLE;
               end else begin
                  timer <= timer + 1'b1;
                  // device pulls data low as line acknowledge
                  if (dev_fall) begin
                     tx_done <= ~data_sync[1];
                     tx_err  <= data_sync[1];
                     state   <= ST_IDLE;
                  end
               end
            end
         endcase
      end
   end

   // outgoing bits, odd parity
   always_ff @(posedge CLK50MHZ) begin
      if (state == ST_IDLE && tx_start)
         shift_q <= {1'b1, ~^tx_byte, tx_byte};
      else if (state == ST_BITS && dev_fall)
         shift_q <= {1'b1, shift_q[9:1]};
   end

endmodule

`default_nettype wire

// ==== ps2_rx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mouse_config.svh"

module ps2_rx (
   input  wire                  CLK50MHZ,
   input  wire                  RST,
   input  wire                  ps2_clk,
   input  wire                  ps2_data,
   input  wire                  enable,
   output mouse_pkg::ps2_byte_t rx_byte,
   output logic                 rx_done,
   output logic                 rx_err
);

   localparam int FLEN = `MOUSE_FILTER_LEN;

   // two-stage synchronizers
   logic [1:0]      clk_sync;
   logic [1:0]      data_sync;
   // older clock samples, newest one is clk_sync[1]
   logic [FLEN-2:0] clk_hist;
   logic            clk_filt;
   logic            clk_fall;
   logic [3:0]      bit_cnt;
   logic [10:0]     frame_q;
   logic [10:0]     frame_next;
   logic            frame_bad;

   always_ff @(posedge CLK50MHZ or posedge RST) begin
      if (RST) begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_hist  <= '1;
         clk_filt  <= 1'b1;
      end else begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         clk_hist  <= {clk_hist[FLEN-3:0], clk_sync[1]};
         // filtered level only moves once the whole window agrees
         if (&{clk_hist, clk_sync[1]})
            clk_filt <= 1'b1;
         else if (clk_fall)
            clk_filt <= 1'b0;
      end
   end

   // clean falling edge of the device clock
   assign clk_fall = clk_filt & ~|{clk_hist, clk_sync[1]};

   // new bit in at the top, start bit lands in bit 0
   assign frame_next = {data_sync[1], frame_q[10:1]};
   // start high, stop low, or even parity over data plus parity bit
   assign frame_bad = frame_next[0] | ~frame_next[10] | ~(^frame_next[9:1]);

   always_ff @(posedge CLK50MHZ or posedge RST) begin
      if (RST) begin
         bit_cnt <= '0;
         rx_done <= 1'b0;
         rx_err  <= 1'b0;
      end else begin
         rx_done <= 1'b0;
         rx_err  <= 1'b0;
         // disabled receiver throws away any partial frame
         if (!enable) begin
            bit_cnt <= '0;
         end else if (clk_fall) begin
            if (bit_cnt == 4'd10) begin
               bit_cnt <= '0;
               rx_done <= ~frame_bad;
               rx_err  <= frame_bad;
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
            end
         end
      end
   end

   // shifter and data byte
   always_ff @(posedge CLK50MHZ) begin
      if (clk_fall)
         frame_q <= frame_next;
      if (clk_fall && bit_cnt == 4'd10)
         rx_byte <= frame_next[8:1];
   end

endmodule

`default_nettype wire

// ==== mouse_pkg.sv ====
`default_nettype none

package mouse_pkg;

   // one data byte on the ps2 wire
   typedef logic [7:0] ps2_byte_t;

   // cursor position, wraps modulo 1024
   typedef logic [9:0] cursor_pos_t;

   // standard 3-byte movement packet
   // byte 0 sits in the top bits, as it arrives first
   typedef struct packed {
      logic      y_ovf;
      logic      x_ovf;
      logic      y_sign;
      logic      x_sign;
      // always 1 in a valid byte 0
      logic      sync;
      logic      btn_middle;
      logic      btn_right;
      logic      btn_left;
      // x movement, sign is x_sign
      ps2_byte_t dx;
      // y movement, sign is y_sign
      ps2_byte_t dy;
   } mouse_packet_t;

endpackage

`default_nettype wire

// ==== mouse_config.svh ====
`ifndef MOUSE_CONFIG_SVH
`define MOUSE_CONFIG_SVH

// samples the clock line must hold before an edge counts
`define MOUSE_FILTER_LEN 8

// host request-to-send inhibit, 100 us at 50 MHz
`define MOUSE_INHIBIT_CYCLES 5000

// give up on the device after about 40 ms
`define MOUSE_TX_TIMEOUT 2000000

// stream-enable command
`define MOUSE_CMD_STREAM 8'hF4
// device acknowledge
`define MOUSE_ACK 8'hFA

`endif
